/* ssf_bank.f */
+incdir+logic
logic/ssf_pkg.sv
logic/start_sequencer.sv
logic/ssf_core.sv
logic/bank_arbiter.sv
logic/ssf_bank.sv
dv/ssf_bank_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f ssf_bank.f --top-module ssf_bank_tb -o ssf_bank_sim \
	&& ./obj_dir/ssf_bank_sim > sim.log 2>&1 \
	|| echo "run_sim: build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "run_sim: passed" && exit 0
echo "run_sim: failed"
exit 1

/* dv/ssf_bank_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ssf_consts.svh"

module ssf_bank_tb
	import ssf_pkg::*;
();

	localparam int NC = `SSF_NCORES;
	localparam int TAPS = `SSF_TAPS;
	localparam int GAP = `SSF_STAGGER;
	localparam int DW = `SSF_DW;
	localparam int NTESTS = 5;
	localparam int LIMIT = (NC * GAP + 200) * NTESTS; // Cycle budget for the whole run
	localparam longint WORD_HI = (longint'(1) <<< (DW - 1)) - 1;
	localparam longint WORD_LO = -(longint'(1) <<< (DW - 1));
	localparam logic signed [DW-1:0] MAX_WORD = DW'(WORD_HI);
	localparam logic signed [DW-1:0] MIN_WORD = DW'(WORD_LO);

	logic                   clk;
	logic                   rst;
	logic signed [DW-1:0]   io_in = '0;
	logic signed [DW-1:0]   io_out;
	req_code_e              req_in;
	out_code_e              out_en;
	logic [`SSF_IDW-1:0]    in_core;
	logic [`SSF_IDW-1:0]    out_core;
	logic [NC-1:0]          running;

	core_state_e          m_state [NC];
	int                   m_taps [NC];
	logic signed [DW-1:0] m_grp [NC][TAPS]; // Words credited to each core in its current group
	int                   m_edges;          // Rising edges since rst went low
	logic [NC-1:0]        m_running;
	logic                 m_reset_edge;
	int                   offer_core;       // Core that has to be on the output this cycle

	int            cyc;
	int            rise_cyc [NC];
	logic [NC-1:0] prev_running;
	int            err [NTESTS];
	int            hits [NTESTS];
	int            sums_seen;
	int            wraps_seen;
	int            offers_seen;
	int            cur_test = 0;
	bit            limit_mode = 1'b0;

	ssf_bank u_ssf_bank (
		.clk      (clk),
		.rst      (rst),
		.io_in    (io_in),
		.io_out   (io_out),
		.req_in   (req_in),
		.out_en   (out_en),
		.in_core  (in_core),
		.out_core (out_core),
		.running  (running)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic signed [DW-1:0] next_word(bit near_limit);
		int unsigned sel;
		logic signed [DW-1:0] w;
		sel = $urandom % 6;
		w = $urandom;
		if (near_limit) begin
			case (sel)
				0: w = MAX_WORD;
				1: w = MAX_WORD - 1;
				2: w = MIN_WORD;
				3: w = MIN_WORD + 1;
				default: w = w;
			endcase
		end
		return w;
	endfunction

	initial begin
		void'($urandom(69));
		forever begin
			@(posedge clk);
			io_in <= next_word(limit_mode);
		end
	end

	function automatic int lowest_in(core_state_e st);
		int found;
		found = -1;
		for (int i = NC - 1; i >= 0; i--) begin
			if (m_state[i] == st) begin
				found = i;
			end
		end
		return found;
	endfunction

	function automatic logic signed [DW-1:0] group_sum(int c);
		logic signed [DW-1:0] s;
		s = '0;
		for (int k = 0; k < TAPS; k++) begin
			s = s + m_grp[c][k]; // Keeps only the low word, so it wraps
		end
		return s;
	endfunction

	function automatic bit group_wraps(int c);
		longint exact;
		bit wrapped;
		exact = 0;
		wrapped = 1'b0;
		for (int k = 0; k < TAPS; k++) begin
			exact = exact + longint'(m_grp[c][k]);
			if (exact > WORD_HI || exact < WORD_LO) begin
				wrapped = 1'b1;
			end
		end
		return wrapped;
	endfunction

	task automatic log_mismatch(int t, string msg);
		err[t]++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	// Applies the next rising edge to the model, using the inputs the DUT will see there
	task automatic step_model(int lo_in, int lo_out);
		int done_core;
		done_core = -1;
		offer_core = -1;
		if (rst) begin
			m_edges = 0;
			for (int i = 0; i < NC; i++) begin
				m_state[i] = ST_HOLD;
				m_taps[i] = 0;
			end
		end else begin
			for (int i = 0; i < NC; i++) begin
				if (!m_running[i]) begin
					m_state[i] = ST_HOLD;
					m_taps[i] = 0;
				end else if (m_state[i] == ST_HOLD) begin
					m_state[i] = ST_FETCH;
				end else if (m_state[i] == ST_FETCH && i == lo_in) begin
					m_grp[i][m_taps[i]] = io_in;
					m_taps[i]++;
					if (m_taps[i] == TAPS) begin
						m_state[i] = ST_EMIT;
						done_core = i;
					end
				end else if (m_state[i] == ST_EMIT && i == lo_out) begin
					m_state[i] = ST_FETCH;
					m_taps[i] = 0;
				end
			end
			if (m_edges <= NC * GAP) begin
				m_edges++;
			end
			if (done_core >= 0 && lowest_in(ST_EMIT) == done_core) begin
				offer_core = done_core;
			end
		end
		m_reset_edge = rst;
		for (int i = 0; i < NC; i++) begin
			m_running[i] = (m_edges >= 1 + i * GAP);
		end
	endtask

	task automatic check_cycle();
		int lo_in;
		int lo_out;
		int rel;
		lo_in = lowest_in(ST_FETCH);
		lo_out = lowest_in(ST_EMIT);
		rel = (cur_test == 4) ? 4 : 0;
		cyc++;
		for (int i = 0; i < NC; i++) begin
			if (running[i] && !prev_running[i]) begin
				rise_cyc[i] = cyc;
			end
		end
		prev_running = running;

		hits[rel]++;
		assert (running == m_running) else
			log_mismatch(rel, $sformatf("running is %b, expected %b", running, m_running));
		if (m_reset_edge) begin
			hits[rel]++;
			assert (running == '0 && req_in == REQ_NONE && out_en == OUT_NONE) else
				log_mismatch(rel, "outputs are not idle in reset");
		end

		hits[1]++;
		assert (req_in == ((lo_in >= 0) ? REQ_DATA : REQ_NONE)) else
			log_mismatch(1, $sformatf("req_in is %0d, lowest fetching core %0d", req_in, lo_in));
		if (lo_in >= 0) begin
			assert (int'(in_core) == lo_in) else
				log_mismatch(1, $sformatf("in_core is %0d, expected %0d", in_core, lo_in));
		end

		hits[3]++;
		assert (out_en == ((lo_out >= 0) ? OUT_DATA : OUT_NONE)) else
			log_mismatch(3, $sformatf("out_en is %0d, lowest pending core %0d", out_en, lo_out));
		if (lo_out >= 0) begin
			hits[2]++;
			assert (int'(out_core) == lo_out) else
				log_mismatch(3, $sformatf("out_core is %0d, expected %0d", out_core, lo_out));
			assert (io_out == group_sum(lo_out)) else
				log_mismatch(2, $sformatf("core %0d sum is %0d, expected %0d",
					lo_out, io_out, group_sum(lo_out)));
			sums_seen++;
			if (group_wraps(lo_out)) begin
				wraps_seen++;
			end
		end
		if (offer_core >= 0) begin
			hits[3]++;
			offers_seen++;
			assert (out_en == OUT_DATA && int'(out_core) == offer_core) else
				log_mismatch(3, $sformatf("core %0d result not offered one cycle after its group",
					offer_core));
		end
		step_model(lo_in, lo_out);
	endtask

	// The model starts in the state of the first reset edge, which rst is high for
	initial begin
		for (int i = 0; i < NC; i++) begin
			m_state[i] = ST_HOLD;
			m_taps[i] = 0;
			rise_cyc[i] = -1;
		end
		for (int t = 0; t < NTESTS; t++) begin
			err[t] = 0;
			hits[t] = 0;
		end
		m_edges = 0;
		m_running = '0;
		m_reset_edge = 1'b1;
		offer_core = -1;
		prev_running = '0;
		cyc = 0;
		sums_seen = 0;
		wraps_seen = 0;
		offers_seen = 0;
		@(posedge clk);
		forever begin
			@(negedge clk);
			check_cycle();
		end
	end

	initial begin
		int run_cyc;
		run_cyc = 0;
		while (run_cyc < LIMIT) begin
			@(posedge clk);
			run_cyc++;
		end
		$display("timeout: the tests were still running after %0d cycles", LIMIT);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic wait_all_running();
		while (running != '1) begin
			@(negedge clk);
		end
		@(posedge clk); // The last rise is recorded at that same negedge
	endtask

	task automatic wait_outputs(int n);
		int base;
		base = sums_seen;
		while (sums_seen < base + n) begin
			@(posedge clk);
		end
	endtask

	task automatic check_spacing();
		for (int i = 1; i < NC; i++) begin
			hits[cur_test]++;
			assert (rise_cyc[i] - rise_cyc[0] == i * GAP) else
				log_mismatch(cur_test, $sformatf("running[%0d] rose %0d cycles after core 0",
					i, rise_cyc[i] - rise_cyc[0]));
		end
	endtask

	task automatic report_test(int t, string name);
		$display("test %0d %s: %s, %0d checks, %0d errors", t + 1, name,
			(err[t] == 0) ? "passed" : "failed", hits[t], err[t]);
	endtask

	initial begin
		int base;
		int total;
		int failed;
		rst = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		wait_all_running();
		check_spacing();
		report_test(0, "reset state and staggered release");

		cur_test = 1;
		wait_outputs(8);
		report_test(1, "input priority");

		cur_test = 2;
		limit_mode = 1'b1; // Groups now mix in words at the signed limits
		base = wraps_seen;
		wait_outputs(12);
		assert (wraps_seen > base) else begin
			err[2]++;
			$display("no group with an overflowing sum reached the output");
		end
		report_test(2, "sum correctness");

		cur_test = 3;
		base = offers_seen;
		while (offers_seen < base + 8) begin
			@(posedge clk);
		end
		report_test(3, "output priority and one-cycle offer");

		cur_test = 4;
		// The model already holds the state after this edge, so reset lands on a busy cycle
		do begin
			@(posedge clk);
		end while (lowest_in(ST_EMIT) < 0 || lowest_in(ST_FETCH) < 0);
		rst <= 1'b1;
		for (int i = 0; i < NC; i++) begin
			rise_cyc[i] = -1;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		wait_all_running();
		check_spacing();
		wait_outputs(8);
		report_test(4, "mid-run reset");

		total = 0;
		failed = 0;
		for (int t = 0; t < NTESTS; t++) begin
			total += err[t];
			if (err[t] != 0) begin
				failed++;
			end
		end
		$display("summary: %0d tests, %0d failed, %0d errors", NTESTS, failed, total);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/ssf_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ssf_consts.svh"

module ssf_bank
	import ssf_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic signed [`SSF_DW-1:0] io_in,
	output logic signed [`SSF_DW-1:0] io_out,
	output req_code_e                 req_in,
	output out_code_e                 out_en,
	output logic [`SSF_IDW-1:0]       in_core,
	output logic [`SSF_IDW-1:0]       out_core,
	output logic [`SSF_NCORES-1:0]    running
);

	core_status_t             core_status [`SSF_NCORES];
	logic [`SSF_NCORES-1:0]   in_grant;
	logic [`SSF_NCORES-1:0]   out_grant;

	start_sequencer u_start_sequencer (
		.clk     (clk),
		.rst     (rst),
		.running (running)
	);

	// All cores see the same input word, only the granted one adds it
	for (genvar i = 0; i < `SSF_NCORES; i++) begin : g_core
		ssf_core u_ssf_core (
			.clk       (clk),
			.rst       (rst),
			.running   (running[i]),
			.io_in     (io_in),
			.in_grant  (in_grant[i]),
			.out_grant (out_grant[i]),
			.status    (core_status[i])
		);
	end

	bank_arbiter u_bank_arbiter (
		.status    (core_status),
		.in_grant  (in_grant),
		.out_grant (out_grant),
		.req_in    (req_in),
		.in_core   (in_core),
		.out_en    (out_en),
		.io_out    (io_out),
		.out_core  (out_core)
	);

endmodule

`default_nettype wire

/* logic/bank_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ssf_consts.svh"

module bank_arbiter
	import ssf_pkg::*;
(
	input  core_status_t              status [`SSF_NCORES],
	output logic [`SSF_NCORES-1:0]    in_grant,
	output logic [`SSF_NCORES-1:0]    out_grant,
	output req_code_e                 req_in,
	output logic [`SSF_IDW-1:0]       in_core,
	output out_code_e                 out_en,
	output logic signed [`SSF_DW-1:0] io_out,
	output logic [`SSF_IDW-1:0]       out_core
);

	localparam int NC  = `SSF_NCORES;
	localparam int IDW = `SSF_IDW;

	logic in_hit;  // Some core is fetching
	logic out_hit; // Some core has a result

	// Lowest requesting index wins the input word
	always_comb begin
		in_hit   = 1'b0;
		in_grant = '0;
		in_core  = '0;
		for (int i = 0; i < NC; i++) begin
			if (!in_hit && status[i].req == REQ_DATA) begin
				in_hit      = 1'b1;
				in_grant[i] = 1'b1;
				in_core     = IDW'(i);
			end
		end
	end

	assign req_in = in_hit ? REQ_DATA : REQ_NONE;

	// Same priority for the output side, chosen independently of the input side
	always_comb begin
		out_hit   = 1'b0;
		out_grant = '0;
		out_core  = '0;
		io_out    = '0;
		for (int i = 0; i < NC; i++) begin
			if (!out_hit && status[i].out_code == OUT_DATA) begin
				out_hit      = 1'b1;
				out_grant[i] = 1'b1;
				out_core     = IDW'(i);
				io_out       = status[i].result;
			end
		end
	end

	assign out_en = out_hit ? OUT_DATA : OUT_NONE;

endmodule

`default_nettype wire

/* logic/ssf_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ssf_consts.svh"

module ssf_core
	import ssf_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      running,
	input  logic signed [`SSF_DW-1:0] io_in,
	input  logic                      in_grant,
	input  logic                      out_grant,
	output core_status_t              status
);

	localparam int TCW = ($clog2(`SSF_TAPS) > 0) ? $clog2(`SSF_TAPS) : 1;
	localparam logic [TCW-1:0] LAST_TAP = TCW'(`SSF_TAPS - 1);

	core_state_e               state;
	core_state_e               state_nx;
	logic [TCW-1:0]            taps;    // Words taken so far in this group
	logic [TCW-1:0]            taps_nx;
	logic signed [`SSF_DW-1:0] acc;     // Running sum, then the result in ST_EMIT
	logic signed [`SSF_DW-1:0] acc_nx;
	logic                      take;
	logic                      last;
	logic                      give;

	assign take = (state == ST_FETCH) && in_grant;
	assign last = (taps == LAST_TAP);
	assign give = (state == ST_EMIT) && out_grant;

	// A low running bit keeps the core parked, like a per-core reset
	always_ff @(posedge clk) begin
		if (rst || !running) begin
			state <= ST_HOLD;
			taps  <= '0;
			acc   <= '0;
		end else begin
			state <= state_nx;
			taps  <= taps_nx;
			acc   <= acc_nx;
		end
	end

	always_comb begin
		state_nx = state;
		taps_nx  = taps;
		acc_nx   = acc;
		unique case (state)
			ST_HOLD: begin
				state_nx = ST_FETCH;
			end
			ST_FETCH: begin
				if (take) begin
					acc_nx = acc + io_in; // Wraps on overflow
					if (last) begin
						state_nx = ST_EMIT;
					end else begin
						taps_nx = taps + 1'b1;
					end
				end
			end
			ST_EMIT: begin
				// Straight back to fetching, the next group starts from zero
				if (give) begin
					state_nx = ST_FETCH;
					taps_nx  = '0;
					acc_nx   = '0;
				end
			end
			default: begin
				state_nx = ST_HOLD;
			end
		endcase
	end

	always_comb begin
		status.req      = (state == ST_FETCH) ? REQ_DATA : REQ_NONE;
		status.out_code = (state == ST_EMIT) ? OUT_DATA : OUT_NONE;
		status.result   = acc; // Only looked at while out_code is OUT_DATA
	end

endmodule

`default_nettype wire

/* logic/start_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ssf_consts.svh"

module start_sequencer (
	input  logic                   clk,
	input  logic                   rst,
	output logic [`SSF_NCORES-1:0] running
);

	localparam int NC = `SSF_NCORES;
	localparam int IW = $clog2(NC + 1); // Counts up to and including NC
	localparam int CW = $clog2(`SSF_STAGGER + 1);
	localparam logic [CW-1:0] GAP = CW'(`SSF_STAGGER - 1);

	logic [IW-1:0] rel_idx; // Next core to release
	logic [CW-1:0] gap_cnt; // Cycles left before that release
	logic          all_run;

	assign all_run = (rel_idx == IW'(NC));

	// The counter starts at zero so core 0 goes on the first edge out of reset
	// Each release reloads the gap, giving exactly SSF_STAGGER edges between cores
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= '0;
			rel_idx <= '0;
			gap_cnt <= '0;
		end else if (!all_run) begin
			if (gap_cnt == '0) begin
				running <= running | (NC'(1) << rel_idx);
				rel_idx <= rel_idx + 1'b1;
				gap_cnt <= GAP;
			end else begin
				gap_cnt <= gap_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/ssf_pkg.sv */
`default_nettype none

`include "ssf_consts.svh"

package ssf_pkg;

	// Code a core puts on the request bus
	typedef enum logic [1:0] {
		REQ_NONE = 2'd0,
		REQ_DATA = 2'd1
	} req_code_e;

	// Code a core puts on the output-enable bus
	typedef enum logic [1:0] {
		OUT_NONE = 2'd0,
		OUT_DATA = 2'd1
	} out_code_e;

	typedef enum logic [1:0] {
		ST_HOLD  = 2'd0, // Not yet released or stopped by reset
		ST_FETCH = 2'd1, // Taking words from the shared input
		ST_EMIT  = 2'd2  // Result waiting for the output bus
	} core_state_e;

	// Everything a core shows to the arbiter
	typedef struct packed {
		req_code_e                 req;
		out_code_e                 out_code;
		logic signed [`SSF_DW-1:0] result;
	} core_status_t;

endpackage

`default_nettype wire

/* logic/ssf_consts.svh */
`ifndef SSF_CONSTS_SVH
`define SSF_CONSTS_SVH

// Number of summing cores sharing the input and output buses
`define SSF_NCORES 4

// Words added together for one result
`define SSF_TAPS 4

// Cycles between the release of core i and core i+1
`define SSF_STAGGER 16

// Width of input words and results, both signed
`define SSF_DW 32

// Width of a core index, follows the core count
`define SSF_IDW $clog2(`SSF_NCORES)

`endif
